// ==== build.f ====
hdl/cachePkg.sv
hdl/cacheStore.sv
hdl/missEngine.sv
hdl/flushEngine.sv
hdl/busArbiter.sv
hdl/dcacheTop.sv
tb/memModel.sv
tb/tbDcache.sv

// ==== hdl/busArbiter.sv ====
module busArbiter
   import cachePkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  busReq_t missReq,
   input  busReq_t flushReq,
   output busRsp_t missRsp,
   output busRsp_t flushRsp,
   output logic    psel,
   output logic    penable,
   output logic    pwrite,
   output addr_t   paddr,
   output word_t   pwdata,
   input  word_t   prdata,
   input  logic    pready
);

   apbState_t state;
   apbState_t nextState;
   logic      grantFlush;      // owner of the current transfer
   logic      pickFlush;
   busReq_t   pick;
   logic      xferDone;

   assign pickFlush = flushReq.valid;     // fixed priority
   assign pick = pickFlush ? flushReq : missReq;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= APB_IDLE;
         grantFlush <= 1'b0;
      end
      else
      begin
         state <= nextState;
         if (state == APB_IDLE && pick.valid)
         begin
            grantFlush <= pickFlush;
         end
      end
   end

   // request captured on the way into setup
   always_ff @(posedge CLK)
   begin
      if (state == APB_IDLE && pick.valid)
      begin
         pwrite <= pick.write;
         paddr <= pick.addr;
         pwdata <= pick.wdata;
      end
   end

   always_comb
   begin
      nextState = state;
      case (state)
         APB_IDLE:   nextState = pick.valid ? APB_SETUP : APB_IDLE;
         APB_SETUP:  nextState = APB_ACCESS;
         APB_ACCESS: nextState = pready ? APB_IDLE : APB_ACCESS;
         default:    nextState = APB_IDLE;
      endcase
   end

   assign psel = (state != APB_IDLE);
   assign penable = (state == APB_ACCESS);
   assign xferDone = penable && pready;

   always_comb
   begin
      missRsp.done = xferDone && !grantFlush;
      missRsp.rdata = grantFlush ? '0 : prdata;
      flushRsp.done = xferDone && grantFlush;
      flushRsp.rdata = grantFlush ? prdata : '0;
   end

endmodule

// ==== hdl/cachePkg.sv ====
package cachePkg;

   localparam int NUM_SETS = 8;
   localparam int NUM_WAYS = 2;
   localparam int WORDS_PER_LINE = 2;
   localparam int TAG_W = 26;
   localparam int INDEX_W = 3;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [WORDS_PER_LINE*32-1:0] line_t;
   typedef logic way_t;

   typedef struct packed {
      logic ren;
      logic wen;
      addr_t addr;
      word_t wdata;
   } cpuReq_t;

   typedef struct packed {
      logic valid;
      logic write;
      addr_t addr;
      word_t wdata;
   } busReq_t;

   typedef struct packed {
      logic done;
      word_t rdata;
   } busRsp_t;

   typedef struct packed {
      logic en;
      way_t way;
      index_t index;
      tag_t tag;
      line_t data;
      logic dirty;
   } fill_t;

   // way tells the miss engine where the line lives
   typedef struct packed {
      logic valid;
      logic dirty;
      way_t way;
      tag_t tag;
      line_t data;
   } victim_t;

   typedef enum logic [2:0] {IDLE, WB0, WB1, FETCH0, FETCH1, INSTALL} missState_t;

   typedef enum logic [2:0] {SCAN, WR0, WR1, NEXT, DONE} flushState_t;

   typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apbState_t;

endpackage

// ==== hdl/cacheStore.sv ====
module cacheStore
   import cachePkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  cpuReq_t cpuReq,
   output logic    hit,
   output logic    miss,
   output word_t   rdata,
   output victim_t victim,
   input  fill_t   fill,
   input  index_t  scanIndex,
   input  way_t    scanWay,
   output victim_t scanEntry
);

   tag_t  tagArr   [NUM_SETS][NUM_WAYS];
   line_t dataArr  [NUM_SETS][NUM_WAYS];
   logic  validArr [NUM_SETS][NUM_WAYS];
   logic  dirtyArr [NUM_SETS][NUM_WAYS];
   way_t  victimPtr [NUM_SETS];           // flips only on fill

   tag_t   reqTag;
   index_t reqIndex;
   logic   reqWord;
   logic   active;
   logic   [NUM_WAYS-1:0] match;
   way_t   hitWay;
   way_t   victimWay;
   line_t  hitLine;
   logic   writeHit;

   assign reqTag = cpuReq.addr[31 -: TAG_W];
   assign reqIndex = cpuReq.addr[3 +: INDEX_W];
   assign reqWord = cpuReq.addr[2];
   assign active = cpuReq.ren | cpuReq.wen;

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         match[w] = validArr[reqIndex][w] && (tagArr[reqIndex][w] == reqTag);
      end
   end

   assign hitWay = way_t'(match[1]);
   assign hit = active && (|match);
   assign miss = active && !(|match);
   assign writeHit = cpuReq.wen && (|match);

   assign hitLine = dataArr[reqIndex][hitWay];
   assign rdata = hitLine[32 * reqWord +: 32];

   assign victimWay = victimPtr[reqIndex];

   always_comb
   begin
      victim.valid = validArr[reqIndex][victimWay];
      victim.dirty = dirtyArr[reqIndex][victimWay];
      victim.way = victimWay;
      victim.tag = tagArr[reqIndex][victimWay];
      victim.data = dataArr[reqIndex][victimWay];
   end

   always_comb
   begin
      scanEntry.valid = validArr[scanIndex][scanWay];
      scanEntry.dirty = dirtyArr[scanIndex][scanWay];
      scanEntry.way = scanWay;
      scanEntry.tag = tagArr[scanIndex][scanWay];
      scanEntry.data = dataArr[scanIndex][scanWay];
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
               validArr[s][w] <= 1'b0;
               dirtyArr[s][w] <= 1'b0;
            end
            victimPtr[s] <= '0;
         end
      end
      else if (fill.en)
      begin
         validArr[fill.index][fill.way] <= 1'b1;
         dirtyArr[fill.index][fill.way] <= fill.dirty;
         victimPtr[fill.index] <= ~fill.way;     // next miss takes the other way
      end
      else if (writeHit)
      begin
         dirtyArr[reqIndex][hitWay] <= 1'b1;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (fill.en)
      begin
         tagArr[fill.index][fill.way] <= fill.tag;
         dataArr[fill.index][fill.way] <= fill.data;
      end
      else if (writeHit)
      begin
         dataArr[reqIndex][hitWay][32 * reqWord +: 32] <= cpuReq.wdata;   // merge one word
      end
   end

endmodule

// ==== hdl/dcacheTop.sv ====
module dcacheTop
   import cachePkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  cpuReq_t cpuReq,
   input  logic    halt,
   output logic    hit,
   output word_t   rdata,
   output logic    flushed,
   output logic    psel,
   output logic    penable,
   output logic    pwrite,
   output addr_t   paddr,
   output word_t   pwdata,
   input  word_t   prdata,
   input  logic    pready
);

   logic    miss;
   victim_t victim;
   fill_t   fill;
   index_t  scanIndex;
   way_t    scanWay;
   victim_t scanEntry;
   busReq_t missReq;
   busReq_t flushReq;
   busRsp_t missRsp;
   busRsp_t flushRsp;

   cacheStore store (
      .CLK(CLK), .nRST(nRST), .cpuReq(cpuReq),
      .hit(hit), .miss(miss), .rdata(rdata), .victim(victim), .fill(fill),
      .scanIndex(scanIndex), .scanWay(scanWay), .scanEntry(scanEntry)
   );

   missEngine missEng (
      .CLK(CLK), .nRST(nRST), .cpuReq(cpuReq), .miss(miss), .victim(victim),
      .busReq(missReq), .busRsp(missRsp), .fill(fill)
   );

   flushEngine flushEng (
      .CLK(CLK), .nRST(nRST), .halt(halt),
      .scanIndex(scanIndex), .scanWay(scanWay), .scanEntry(scanEntry),
      .busReq(flushReq), .busRsp(flushRsp), .flushed(flushed)
   );

   busArbiter arb (
      .CLK(CLK), .nRST(nRST),
      .missReq(missReq), .flushReq(flushReq), .missRsp(missRsp), .flushRsp(flushRsp),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready)
   );

endmodule

// ==== hdl/flushEngine.sv ====
module flushEngine
   import cachePkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  logic    halt,
   output index_t  scanIndex,
   output way_t    scanWay,
   input  victim_t scanEntry,
   output busReq_t busReq,
   input  busRsp_t busRsp,
   output logic    flushed
);

   flushState_t state;
   flushState_t nextState;
   logic [INDEX_W:0] scanCount;       // {index, way}
   logic lastEntry;
   logic needWb;

   assign scanIndex = scanCount[INDEX_W:1];
   assign scanWay = scanCount[0];
   assign lastEntry = (scanCount == $bits(scanCount)'(NUM_SETS * NUM_WAYS - 1));
   assign needWb = scanEntry.valid && scanEntry.dirty;
   assign flushed = (state == DONE);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= SCAN;
         scanCount <= '0;
      end
      else
      begin
         state <= nextState;
         if (state == NEXT && !lastEntry)
         begin
            scanCount <= scanCount + 1'b1;
         end
      end
   end

   always_comb
   begin
      nextState = state;
      case (state)
         SCAN:
         begin
            if (halt)
            begin
               nextState = needWb ? WR0 : NEXT;
            end
         end
         WR0:     nextState = busRsp.done ? WR1 : WR0;
         WR1:     nextState = busRsp.done ? NEXT : WR1;
         NEXT:    nextState = lastEntry ? DONE : SCAN;
         DONE:    nextState = DONE;
         default: nextState = SCAN;
      endcase
   end

   always_comb
   begin
      busReq = '0;
      if (state == WR0 || state == WR1)
      begin
         busReq.valid = 1'b1;
         busReq.write = 1'b1;
         busReq.addr = {scanEntry.tag, scanIndex, (state == WR1), 2'b00};
         busReq.wdata = (state == WR1) ? scanEntry.data[63:32] : scanEntry.data[31:0];
      end
   end

endmodule

// ==== hdl/missEngine.sv ====
module missEngine
   import cachePkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  cpuReq_t cpuReq,
   input  logic    miss,
   input  victim_t victim,
   output busReq_t busReq,
   input  busRsp_t busRsp,
   output fill_t   fill
);

   missState_t state;
   missState_t nextState;
   way_t       fillWay;
   line_t      lineBuf;
   tag_t       reqTag;
   index_t     reqIndex;

   assign reqTag = cpuReq.addr[31 -: TAG_W];
   assign reqIndex = cpuReq.addr[3 +: INDEX_W];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
         fillWay <= '0;
      end
      else
      begin
         state <= nextState;
         if (state == IDLE && miss)
         begin
            fillWay <= victim.way;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (busRsp.done && state == FETCH0)
      begin
         lineBuf[31:0] <= busRsp.rdata;
      end
      else if (busRsp.done && state == FETCH1)
      begin
         lineBuf[63:32] <= busRsp.rdata;
      end
   end

   always_comb
   begin
      nextState = state;
      case (state)
         IDLE:
         begin
            if (miss)
            begin
               nextState = (victim.valid && victim.dirty) ? WB0 : FETCH0;
            end
         end
         WB0:     nextState = busRsp.done ? WB1 : WB0;
         WB1:     nextState = busRsp.done ? FETCH0 : WB1;
         FETCH0:  nextState = busRsp.done ? FETCH1 : FETCH0;
         FETCH1:  nextState = busRsp.done ? INSTALL : FETCH1;
         INSTALL: nextState = IDLE;
         default: nextState = IDLE;
      endcase
   end

   always_comb
   begin
      busReq = '0;
      case (state)
         WB0:
         begin
            busReq.valid = 1'b1;
            busReq.write = 1'b1;
            busReq.addr = {victim.tag, reqIndex, 1'b0, 2'b00};
            busReq.wdata = victim.data[31:0];
         end
         WB1:
         begin
            busReq.valid = 1'b1;
            busReq.write = 1'b1;
            busReq.addr = {victim.tag, reqIndex, 1'b1, 2'b00};
            busReq.wdata = victim.data[63:32];
         end
         FETCH0:
         begin
            busReq.valid = 1'b1;
            busReq.addr = {reqTag, reqIndex, 1'b0, 2'b00};
         end
         FETCH1:
         begin
            busReq.valid = 1'b1;
            busReq.addr = {reqTag, reqIndex, 1'b1, 2'b00};
         end
         default:
         begin
            busReq = '0;
         end
      endcase
   end

   always_comb
   begin
      fill.en = (state == INSTALL);
      fill.way = fillWay;
      fill.index = reqIndex;
      fill.tag = reqTag;
      fill.data = lineBuf;
      fill.dirty = 1'b0;       // a write miss dirties it on the following hit
   end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbDcache -f build.f -o simDcache \
   && ./obj_dir/simDcache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && exit 0 || exit 1

// ==== tb/memModel.sv ====
module memModel
   import cachePkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   input  logic  psel,
   input  logic  penable,
   input  logic  pwrite,
   input  addr_t paddr,
   input  word_t pwdata,
   output word_t prdata,
   output logic  pready
);

   localparam int DEPTH = 1024;      // 4 KB window, paddr[11:2]

   word_t words [DEPTH];             // testbench also peeks here

   initial
   begin
      pready = 1'b0;
      for (int i = 0; i < DEPTH; i++)
      begin
         words[i] = word_t'(i) * 32'h9e3779b9 + 32'h0badf00d;   // distinct per word
      end
   end

   assign prdata = words[paddr[11:2]];

   // write lands on the edge that ends the access phase
   always @(posedge CLK)
   begin
      if (psel && penable && pready && pwrite)
      begin
         words[paddr[11:2]] = pwdata;
      end
   end

   always @(posedge CLK)
   begin
      #1;
      pready = nRST && (($urandom % 4) != 0);   // about one wait state in four
   end

endmodule

// ==== tb/tbDcache.sv ====
module tbDcache
   import cachePkg::*;
();

   localparam int HIT_TIMEOUT = 400;
   localparam int FLUSH_TIMEOUT = 5000;
   localparam int MEM_WORDS = 1024;
   localparam int RANDOM_OPS = 300;

   logic    CLK;
   logic    nRST;
   cpuReq_t cpuReq;
   logic    halt;
   logic    hit;
   word_t   rdata;
   logic    flushed;
   logic    psel;
   logic    penable;
   logic    pwrite;
   addr_t   paddr;
   word_t   pwdata;
   word_t   prdata;
   logic    pready;

   word_t shadow [MEM_WORDS];
   int    apbReads;
   int    apbWrites;
   logic  xferWrite [$];           // direction of each finished transfer

   dcacheTop UUT (
      .CLK(CLK), .nRST(nRST), .cpuReq(cpuReq), .halt(halt),
      .hit(hit), .rdata(rdata), .flushed(flushed),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready)
   );

   memModel memory (
      .CLK(CLK), .nRST(nRST), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
   );

   always #4 CLK = ~CLK;

   function automatic addr_t makeAddr(int tag, int index, int word);
      return addr_t'((tag << 6) | (index << 3) | (word << 2));
   endfunction

   // expected read data, from the shadow of every issued write
   function automatic word_t expectedWord(addr_t a);
      return shadow[a[11:2]];
   endfunction

   task automatic stopOnError(string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkWord(word_t got, word_t exp, string what);
      if (got !== exp)
         stopOnError($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic checkCount(int got, int exp, string what);
      if (got != exp)
         stopOnError($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
   endtask

   task automatic checkFlag(logic got, logic exp, string what);
      if (got !== exp)
         stopOnError($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   // holds the request until hit is seen at an edge
   task automatic access(logic write, addr_t a, word_t d);
      int   cycles;
      logic done;
      cpuReq.ren = !write;
      cpuReq.wen = write;
      cpuReq.addr = a;
      cpuReq.wdata = d;
      cycles = 0;
      done = 1'b0;
      while (!done)
      begin
         @(posedge CLK);
         if (hit)
            done = 1'b1;
         else
         begin
            cycles++;
            if (cycles > HIT_TIMEOUT)
               stopOnError($sformatf("timeout: no hit for address %h after %0d cycles",
                                     a, cycles));
         end
      end
      if (write)
         shadow[a[11:2]] = d;
      #1;
      cpuReq = '0;
   endtask

   task automatic accessCountingTraffic(logic write, addr_t a, word_t d, int reads, int writes,
                                        string what);
      int r0;
      int w0;
      r0 = apbReads;
      w0 = apbWrites;
      access(write, a, d);
      checkCount(apbReads - r0, reads, {what, " APB reads"});
      checkCount(apbWrites - w0, writes, {what, " APB writes"});
   endtask

   always @(posedge CLK)
   begin
      if (nRST && cpuReq.ren && hit)
         checkWord(rdata, expectedWord(cpuReq.addr), "read data");
   end

   always @(posedge CLK)
   begin
      if (psel && penable && pready)
      begin
         xferWrite.push_back(pwrite);
         if (pwrite)
            apbWrites++;
         else
            apbReads++;
      end
   end

   initial
   begin
      addr_t a;
      logic  wr;
      int    cycles;
      void'($urandom(32'hd68cd549));
      CLK = 1'b0;
      nRST = 1'b0;
      halt = 1'b0;
      cpuReq = '0;
      apbReads = 0;
      apbWrites = 0;
      repeat (16) @(posedge CLK);
      #1;
      nRST = 1'b1;
      for (int i = 0; i < MEM_WORDS; i++)
         shadow[i] = memory.words[i];      // memory starts from its own pattern
      checkFlag(hit, 1'b0, "hit after reset");
      checkFlag(flushed, 1'b0, "flushed after reset");

      accessCountingTraffic(1'b0, makeAddr(1, 2, 0), '0, 2, 0, "cold read");
      accessCountingTraffic(1'b1, makeAddr(1, 2, 1), 32'hcafe0001, 0, 0, "write hit");
      accessCountingTraffic(1'b0, makeAddr(1, 2, 1), '0, 0, 0, "read after write");
      accessCountingTraffic(1'b0, makeAddr(1, 2, 1), '0, 0, 0, "repeated read");

      // set 5: A in way 0, B in way 1, both dirty, C evicts way 0
      accessCountingTraffic(1'b0, makeAddr(3, 5, 0), '0, 2, 0, "fill way 0");
      accessCountingTraffic(1'b0, makeAddr(4, 5, 0), '0, 2, 0, "fill way 1");
      accessCountingTraffic(1'b1, makeAddr(3, 5, 0), 32'ha0a0a0a0, 0, 0, "dirty way 0");
      accessCountingTraffic(1'b1, makeAddr(4, 5, 1), 32'hb1b1b1b1, 0, 0, "dirty way 1");
      xferWrite.delete();
      accessCountingTraffic(1'b0, makeAddr(5, 5, 1), '0, 2, 2, "dirty eviction");
      checkFlag(xferWrite[0], 1'b1, "eviction transfer 0 is a write");
      checkFlag(xferWrite[1], 1'b1, "eviction transfer 1 is a write");
      checkFlag(xferWrite[2], 1'b0, "eviction transfer 2 is a read");
      checkFlag(xferWrite[3], 1'b0, "eviction transfer 3 is a read");
      a = makeAddr(3, 5, 0);
      checkWord(memory.words[a[11:2]], 32'ha0a0a0a0, "victim word 0 in memory");
      a = makeAddr(3, 5, 1);
      checkWord(memory.words[a[11:2]], expectedWord(a), "victim word 1 in memory");
      accessCountingTraffic(1'b0, makeAddr(4, 5, 1), '0, 0, 0, "way 1 kept");

      // set 6: a hit on A must not save it from C
      accessCountingTraffic(1'b0, makeAddr(7, 6, 0), '0, 2, 0, "fill A");
      accessCountingTraffic(1'b0, makeAddr(8, 6, 0), '0, 2, 0, "fill B");
      accessCountingTraffic(1'b0, makeAddr(7, 6, 1), '0, 0, 0, "hit A");
      accessCountingTraffic(1'b0, makeAddr(9, 6, 0), '0, 2, 0, "miss C");
      accessCountingTraffic(1'b0, makeAddr(8, 6, 1), '0, 0, 0, "B still cached");
      accessCountingTraffic(1'b0, makeAddr(7, 6, 0), '0, 2, 0, "A was evicted");

      for (int n = 0; n < RANDOM_OPS; n++)
      begin
         a = makeAddr(10 + $urandom % 6, $urandom % 4, $urandom % 2);
         wr = ($urandom % 2) == 1;
         access(wr, a, $urandom);
      end

      halt = 1'b1;
      cycles = 0;
      while (!flushed)
      begin
         @(posedge CLK);
         cycles++;
         if (cycles > FLUSH_TIMEOUT)
            stopOnError("timeout: flushed did not rise after halt");
      end
      repeat (20)
      begin
         @(posedge CLK);
         checkFlag(flushed, 1'b1, "flushed held high");
      end
      for (int i = 0; i < MEM_WORDS; i++)
         checkWord(memory.words[i], shadow[i], $sformatf("memory word %0d after flush", i));

      $display("Simulation passed");
      $finish;
   end

endmodule
